//--- Bender.yml
package:
  name: cpu_top

sources:
  - common/cpu_pkg.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/hazard_unit.sv
  - logic/alu_stage.sv
  - logic/wb_arbiter.sv
  - logic/reg_bank.sv
  - mul_pipe/mul_pipe.sv
  - logic/cpu_top.sv
  - target: test
    files:
      - tests/cpu_top_sva.sv
      - tests/cpu_top_tb.sv

//--- common/cpu_pkg.sv
package cpu_pkg;

  // Architectural register file
  localparam int NUM_REGS = 32;

  // Byte step between sequential instructions
  localparam int PC_STEP = 4;

  typedef logic [4:0] reg_idx_t;

  // Major opcodes handled by the decoder, everything else is a NOP
  typedef enum logic [6:0] {
    OPC_OP     = 7'h33,
    OPC_OP_IMM = 7'h13
  } rv_opcode_e;

  // Operation carried into the ALU stage
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

endpackage

//--- logic/alu_stage.sv
`timescale 1ns/1ps

module alu_stage #(
  parameter int XLEN = 32
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              hold_i,
  input  logic              valid_i,
  input  cpu_pkg::alu_op_e  op_i,
  input  logic [XLEN-1:0]   a_i,
  input  logic [XLEN-1:0]   b_i,
  input  cpu_pkg::reg_idx_t rd_i,
  input  logic [XLEN-1:0]   pc_i,
  output logic              valid_o,
  output cpu_pkg::reg_idx_t rd_o,
  output logic [XLEN-1:0]   pc_o,
  output logic [XLEN-1:0]   result_o
);
  import cpu_pkg::*;

  alu_op_e         op_q;
  logic [XLEN-1:0] a_q;
  logic [XLEN-1:0] b_q;

  // Entry stays put while the multiplier owns writeback
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_o <= 1'b0;
    end else if (!hold_i) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!hold_i) begin
      op_q <= op_i;
      a_q  <= a_i;
      b_q  <= b_i;
      rd_o <= rd_i;
      pc_o <= pc_i;
    end
  end

  always_comb begin
    case (op_q)
      ALU_SUB: result_o = a_q - b_q;
      ALU_AND: result_o = a_q & b_q;
      ALU_OR:  result_o = a_q | b_q;
      ALU_XOR: result_o = a_q ^ b_q;
      default: result_o = a_q + b_q;
    endcase
  end

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
  parameter int XLEN       = 32,
  parameter int MUL_STAGES = 5
) (
  input  logic              clk_i,
  input  logic              rst_i,
  output logic [XLEN-1:0]   imem_addr_o,
  input  logic [XLEN-1:0]   imem_rdata_i,
  output logic              retire_valid_o,
  output logic [XLEN-1:0]   retire_pc_o,
  output cpu_pkg::reg_idx_t retire_rd_o,
  output logic [XLEN-1:0]   retire_data_o
);

  logic                  stall;
  logic                  bubble;
  logic                  dec_valid;
  logic [XLEN-1:0]       dec_pc;
  logic [XLEN-1:0]       dec_instr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  cpu_pkg::reg_idx_t     dec_rs1;
  cpu_pkg::reg_idx_t     dec_rs2;
  cpu_pkg::reg_idx_t     dec_rd;
  logic                  dec_uses_rs2;

  // Decode to ALU register inputs
  logic                  alu_in_valid;
  cpu_pkg::alu_op_e      alu_in_op;
  logic [XLEN-1:0]       alu_in_a;
  logic [XLEN-1:0]       alu_in_b;
  cpu_pkg::reg_idx_t     alu_in_rd;
  logic [XLEN-1:0]       alu_in_pc;

  // EX1 register
  logic                  ex1_valid;
  logic [XLEN-1:0]       ex1_a;
  logic [XLEN-1:0]       ex1_b;
  cpu_pkg::reg_idx_t     ex1_rd;
  logic [XLEN-1:0]       ex1_pc;

  logic                  alu_valid;
  cpu_pkg::reg_idx_t     alu_rd;
  logic [XLEN-1:0]       alu_pc;
  logic [XLEN-1:0]       alu_result;
  logic                  alu_hold;

  logic [MUL_STAGES-1:0] mul_stage_valid;
  cpu_pkg::reg_idx_t     mul_stage_rd [MUL_STAGES];
  logic                  mul_done;
  cpu_pkg::reg_idx_t     mul_rd;
  logic [XLEN-1:0]       mul_pc;
  logic [XLEN-1:0]       mul_result;

  logic                  wb_en;
  cpu_pkg::reg_idx_t     wb_rd;
  logic [XLEN-1:0]       wb_data;

  fetch_stage #(
    .XLEN        (XLEN)
  ) i_fetch_stage (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .stall_i     (stall),
    .instr_i     (imem_rdata_i),
    .imem_addr_o (imem_addr_o),
    .dec_valid_o (dec_valid),
    .dec_pc_o    (dec_pc),
    .dec_instr_o (dec_instr)
  );

  decode_stage #(
    .XLEN        (XLEN),
    .MUL_STAGES  (MUL_STAGES)
  ) i_decode_stage (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .valid_i     (dec_valid),
    .pc_i        (dec_pc),
    .instr_i     (dec_instr),
    .stall_i     (stall),
    .bubble_i    (bubble),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .wb_en_i     (wb_en),
    .wb_rd_i     (wb_rd),
    .wb_data_i   (wb_data),
    .rs1_o       (dec_rs1),
    .rs2_o       (dec_rs2),
    .rd_o        (dec_rd),
    .uses_rs2_o  (dec_uses_rs2),
    .alu_valid_o (alu_in_valid),
    .alu_op_o    (alu_in_op),
    .alu_a_o     (alu_in_a),
    .alu_b_o     (alu_in_b),
    .alu_rd_o    (alu_in_rd),
    .alu_pc_o    (alu_in_pc),
    .mul_valid_o (ex1_valid),
    .mul_a_o     (ex1_a),
    .mul_b_o     (ex1_b),
    .mul_rd_o    (ex1_rd),
    .mul_pc_o    (ex1_pc)
  );

  hazard_unit #(
    .MUL_STAGES  (MUL_STAGES)
  ) i_hazard_unit (
    .dec_valid_i (dec_valid),
    .rs1_i       (dec_rs1),
    .rs2_i       (dec_rs2),
    .rd_i        (dec_rd),
    .uses_rs2_i  (dec_uses_rs2),
    .alu_valid_i (alu_valid),
    .alu_rd_i    (alu_rd),
    .alu_hold_i  (alu_hold),
    .mul_valid_i (mul_stage_valid),
    .mul_rd_i    (mul_stage_rd),
    .stall_o     (stall),
    .bubble_o    (bubble)
  );

  alu_stage #(
    .XLEN     (XLEN)
  ) i_alu_stage (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .hold_i   (alu_hold),
    .valid_i  (alu_in_valid),
    .op_i     (alu_in_op),
    .a_i      (alu_in_a),
    .b_i      (alu_in_b),
    .rd_i     (alu_in_rd),
    .pc_i     (alu_in_pc),
    .valid_o  (alu_valid),
    .rd_o     (alu_rd),
    .pc_o     (alu_pc),
    .result_o (alu_result)
  );

  mul_pipe #(
    .XLEN          (XLEN),
    .NUM_STAGES    (MUL_STAGES)
  ) i_mul_pipe (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .valid_i       (ex1_valid),
    .a_i           (ex1_a),
    .b_i           (ex1_b),
    .rd_i          (ex1_rd),
    .pc_i          (ex1_pc),
    .stage_valid_o (mul_stage_valid),
    .stage_rd_o    (mul_stage_rd),
    .done_o        (mul_done),
    .rd_o          (mul_rd),
    .pc_o          (mul_pc),
    .result_o      (mul_result)
  );

  wb_arbiter #(
    .XLEN           (XLEN)
  ) i_wb_arbiter (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .alu_valid_i    (alu_valid),
    .alu_rd_i       (alu_rd),
    .alu_pc_i       (alu_pc),
    .alu_result_i   (alu_result),
    .mul_done_i     (mul_done),
    .mul_rd_i       (mul_rd),
    .mul_pc_i       (mul_pc),
    .mul_result_i   (mul_result),
    .alu_hold_o     (alu_hold),
    .wb_en_o        (wb_en),
    .wb_rd_o        (wb_rd),
    .wb_data_o      (wb_data),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

  reg_bank #(
    .XLEN      (XLEN)
  ) i_reg_bank (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rd_a_i    (dec_rs1),
    .rd_b_i    (dec_rs2),
    .wr_en_i   (wb_en),
    .wr_rd_i   (wb_rd),
    .wr_data_i (wb_data),
    .a_data_o  (rs1_data),
    .b_data_o  (rs2_data)
  );

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
  parameter int XLEN       = 32,
  parameter int MUL_STAGES = 5
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              valid_i,
  input  logic [XLEN-1:0]   pc_i,
  input  logic [XLEN-1:0]   instr_i,
  input  logic              stall_i,
  input  logic              bubble_i,
  input  logic [XLEN-1:0]   rs1_data_i,
  input  logic [XLEN-1:0]   rs2_data_i,
  input  logic              wb_en_i,
  input  cpu_pkg::reg_idx_t wb_rd_i,
  input  logic [XLEN-1:0]   wb_data_i,
  output cpu_pkg::reg_idx_t rs1_o,
  output cpu_pkg::reg_idx_t rs2_o,
  output cpu_pkg::reg_idx_t rd_o,
  output logic              uses_rs2_o,
  output logic              alu_valid_o,
  output cpu_pkg::alu_op_e  alu_op_o,
  output logic [XLEN-1:0]   alu_a_o,
  output logic [XLEN-1:0]   alu_b_o,
  output cpu_pkg::reg_idx_t alu_rd_o,
  output logic [XLEN-1:0]   alu_pc_o,
  output logic              mul_valid_o,
  output logic [XLEN-1:0]   mul_a_o,
  output logic [XLEN-1:0]   mul_b_o,
  output cpu_pkg::reg_idx_t mul_rd_o,
  output logic [XLEN-1:0]   mul_pc_o
);
  import cpu_pkg::*;

  rv_opcode_e      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  reg_idx_t        rs1;
  reg_idx_t        rs2;
  reg_idx_t        rd;
  logic            is_alu;
  logic            is_mul;
  logic            use_imm;
  alu_op_e         op;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;

  assign opcode = rv_opcode_e'(instr_i[6:0]);
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];
  assign imm    = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};

  always_comb begin
    is_alu  = 1'b0;
    is_mul  = 1'b0;
    use_imm = 1'b0;
    op      = ALU_ADD;
    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'h01) begin
          is_mul = (funct3 == 3'd0);
        end else if (funct7 == 7'h00) begin
          is_alu = 1'b1;
          case (funct3)
            3'd0:    op = ALU_ADD;
            3'd4:    op = ALU_XOR;
            3'd6:    op = ALU_OR;
            3'd7:    op = ALU_AND;
            default: is_alu = 1'b0;
          endcase
        end else if (funct7 == 7'h20) begin
          is_alu = (funct3 == 3'd0);
          op     = ALU_SUB;
        end
      end
      OPC_OP_IMM: begin
        is_alu  = (funct3 == 3'd0);
        use_imm = 1'b1;
      end
      default: ;
    endcase
  end

  assign rs1_o      = rs1;
  assign rs2_o      = rs2;
  assign rd_o       = rd;
  assign uses_rs2_o = (opcode == OPC_OP);

  // Writeback lands at the end of this cycle, x0 never bypasses
  assign rs1_val = (wb_en_i && wb_rd_i == rs1 && rs1 != '0) ? wb_data_i : rs1_data_i;
  assign rs2_val = (wb_en_i && wb_rd_i == rs2 && rs2 != '0) ? wb_data_i : rs2_data_i;

  // Inputs of the ALU stage register
  assign alu_valid_o = valid_i & is_alu & ~bubble_i;
  assign alu_op_o    = op;
  assign alu_a_o     = rs1_val;
  assign alu_b_o     = use_imm ? imm : rs2_val;
  assign alu_rd_o    = rd;
  assign alu_pc_o    = pc_i;

  // EX1 register, first stage of the multiplier
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      mul_valid_o <= 1'b0;
    end else begin
      mul_valid_o <= valid_i & is_mul & ~bubble_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      mul_a_o  <= rs1_val;
      mul_b_o  <= rs2_val;
      mul_rd_o <= rd;
      mul_pc_o <= pc_i;
    end
  end

  if (MUL_STAGES < 1) begin : g_bad_mul_stages
    $error("MUL_STAGES must be at least 1");
  end

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
  parameter int XLEN = 32
) (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            stall_i,
  input  logic [XLEN-1:0] instr_i,
  output logic [XLEN-1:0] imem_addr_o,
  output logic            dec_valid_o,
  output logic [XLEN-1:0] dec_pc_o,
  output logic [XLEN-1:0] dec_instr_o
);
  import cpu_pkg::*;

  logic [XLEN-1:0] pc_q;

  // Instruction memory answers in the same cycle
  assign imem_addr_o = pc_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pc_q        <= '0;
      dec_valid_o <= 1'b0;
    end else if (!stall_i) begin
      pc_q        <= pc_q + XLEN'(PC_STEP);
      dec_valid_o <= 1'b1;
    end
  end

  // Fetch to decode register
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      dec_pc_o    <= pc_q;
      dec_instr_o <= instr_i;
    end
  end

endmodule

//--- logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit #(
  parameter int MUL_STAGES = 5
) (
  input  logic                  dec_valid_i,
  input  cpu_pkg::reg_idx_t     rs1_i,
  input  cpu_pkg::reg_idx_t     rs2_i,
  input  cpu_pkg::reg_idx_t     rd_i,
  input  logic                  uses_rs2_i,
  input  logic                  alu_valid_i,
  input  cpu_pkg::reg_idx_t     alu_rd_i,
  input  logic                  alu_hold_i,
  input  logic [MUL_STAGES-1:0] mul_valid_i,
  input  cpu_pkg::reg_idx_t     mul_rd_i [MUL_STAGES],
  output logic                  stall_o,
  output logic                  bubble_o
);
  import cpu_pkg::*;

  logic conflict;

  // RAW on either source or WAW on the destination
  function automatic logic clashes(reg_idx_t wr_rd);
    return (wr_rd != '0) &&
           (wr_rd == rs1_i || (uses_rs2_i && wr_rd == rs2_i) || wr_rd == rd_i);
  endfunction

  always_comb begin
    conflict = alu_valid_i && clashes(alu_rd_i);
    for (int k = 0; k < MUL_STAGES; k++) begin
      conflict = conflict | (mul_valid_i[k] && clashes(mul_rd_i[k]));
    end
  end

  assign stall_o  = dec_valid_i & (conflict | alu_hold_i);

  // Nothing enters ALU or EX1 while decode waits
  assign bubble_o = stall_o;

endmodule

//--- logic/reg_bank.sv
`timescale 1ns/1ps

module reg_bank #(
  parameter int XLEN = 32
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  cpu_pkg::reg_idx_t rd_a_i,
  input  cpu_pkg::reg_idx_t rd_b_i,
  input  logic              wr_en_i,
  input  cpu_pkg::reg_idx_t wr_rd_i,
  input  logic [XLEN-1:0]   wr_data_i,
  output logic [XLEN-1:0]   a_data_o,
  output logic [XLEN-1:0]   b_data_o
);
  import cpu_pkg::*;

  logic [XLEN-1:0] regs_q [NUM_REGS];

  // x0 is never written, so it keeps its reset zero
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && wr_rd_i != '0) begin
      regs_q[wr_rd_i] <= wr_data_i;
    end
  end

  assign a_data_o = regs_q[rd_a_i];
  assign b_data_o = regs_q[rd_b_i];

endmodule

//--- logic/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter #(
  parameter int XLEN = 32
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              alu_valid_i,
  input  cpu_pkg::reg_idx_t alu_rd_i,
  input  logic [XLEN-1:0]   alu_pc_i,
  input  logic [XLEN-1:0]   alu_result_i,
  input  logic              mul_done_i,
  input  cpu_pkg::reg_idx_t mul_rd_i,
  input  logic [XLEN-1:0]   mul_pc_i,
  input  logic [XLEN-1:0]   mul_result_i,
  output logic              alu_hold_o,
  output logic              wb_en_o,
  output cpu_pkg::reg_idx_t wb_rd_o,
  output logic [XLEN-1:0]   wb_data_o,
  output logic              retire_valid_o,
  output logic [XLEN-1:0]   retire_pc_o,
  output cpu_pkg::reg_idx_t retire_rd_o,
  output logic [XLEN-1:0]   retire_data_o
);

  logic [XLEN-1:0] wb_pc;

  // Multiplier cannot stall, so it always wins
  assign alu_hold_o = alu_valid_i & mul_done_i;
  assign wb_en_o    = mul_done_i | alu_valid_i;
  assign wb_rd_o    = mul_done_i ? mul_rd_i     : alu_rd_i;
  assign wb_data_o  = mul_done_i ? mul_result_i : alu_result_i;
  assign wb_pc      = mul_done_i ? mul_pc_i     : alu_pc_i;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= wb_en_o;
    end
  end

  always_ff @(posedge clk_i) begin
    retire_pc_o   <= wb_pc;
    retire_rd_o   <= wb_rd_o;
    retire_data_o <= wb_data_o;
  end

endmodule

//--- mul_pipe/mul_pipe.sv
`timescale 1ns/1ps

module mul_pipe #(
  parameter int XLEN       = 32,
  parameter int NUM_STAGES = 5
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  valid_i,
  input  logic [XLEN-1:0]       a_i,
  input  logic [XLEN-1:0]       b_i,
  input  cpu_pkg::reg_idx_t     rd_i,
  input  logic [XLEN-1:0]       pc_i,
  output logic [NUM_STAGES-1:0] stage_valid_o,
  output cpu_pkg::reg_idx_t     stage_rd_o [NUM_STAGES],
  output logic                  done_o,
  output cpu_pkg::reg_idx_t     rd_o,
  output logic [XLEN-1:0]       pc_o,
  output logic [XLEN-1:0]       result_o
);
  import cpu_pkg::*;

  logic [NUM_STAGES-1:0] valid_s;
  reg_idx_t              rd_s  [NUM_STAGES];
  logic [XLEN-1:0]       pc_s  [NUM_STAGES];
  logic [XLEN-1:0]       res_s [NUM_STAGES];

  // Stage 0 is the EX1 register, product keeps the low XLEN bits
  assign valid_s[0] = valid_i;
  assign rd_s[0]    = rd_i;
  assign pc_s[0]    = pc_i;
  assign res_s[0]   = a_i * b_i;

  for (genvar k = 1; k < NUM_STAGES; k++) begin : g_stage
    always_ff @(posedge clk_i) begin
      if (!rst_i) begin
        valid_s[k] <= 1'b0;
      end else begin
        valid_s[k] <= valid_s[k-1];
      end
    end

    always_ff @(posedge clk_i) begin
      rd_s[k]  <= rd_s[k-1];
      pc_s[k]  <= pc_s[k-1];
      res_s[k] <= res_s[k-1];
    end
  end

  assign stage_valid_o = valid_s;
  assign stage_rd_o    = rd_s;
  assign done_o        = valid_s[NUM_STAGES-1];
  assign rd_o          = rd_s[NUM_STAGES-1];
  assign pc_o          = pc_s[NUM_STAGES-1];
  assign result_o      = res_s[NUM_STAGES-1];

endmodule

//--- sources.f
common/cpu_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/hazard_unit.sv
logic/alu_stage.sv
logic/wb_arbiter.sv
logic/reg_bank.sv
mul_pipe/mul_pipe.sv
logic/cpu_top.sv
tests/cpu_top_sva.sv
tests/cpu_top_tb.sv

//--- tests/cpu_top_sva.sv
`timescale 1ns/1ps

module cpu_top_sva #(
  parameter int XLEN = 32
) (
  input logic              clk_i,
  input logic              rst_i,
  input logic [XLEN-1:0]   imem_addr_i,
  input logic              retire_valid_i,
  input logic [XLEN-1:0]   retire_pc_i,
  input cpu_pkg::reg_idx_t retire_rd_i,
  input logic [XLEN-1:0]   retire_data_i
);

  int fail_count;

  a_quiet_after_reset: assert property (@(posedge clk_i) !rst_i |=> !retire_valid_i)
    else begin
      $error("retire_valid_o high in the cycle after reset");
      fail_count++;
    end

  a_retire_known: assert property (@(posedge clk_i) disable iff (!rst_i)
      retire_valid_i |-> !$isunknown({retire_pc_i, retire_rd_i, retire_data_i}))
    else begin
      $error("retire outputs carry X while retire_valid_o is high");
      fail_count++;
    end

  // Fetch either holds or moves to the next word
  a_fetch_step: assert property (@(posedge clk_i) rst_i && $past(rst_i) |->
      imem_addr_i == $past(imem_addr_i) || imem_addr_i == $past(imem_addr_i) + XLEN'(4))
    else begin
      $error("imem_addr_o neither held nor stepped by 4");
      fail_count++;
    end

endmodule

bind cpu_top cpu_top_sva #(
  .XLEN           (XLEN)
) i_cpu_top_sva (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .imem_addr_i    (imem_addr_o),
  .retire_valid_i (retire_valid_o),
  .retire_pc_i    (retire_pc_o),
  .retire_rd_i    (retire_rd_o),
  .retire_data_i  (retire_data_o)
);

//--- tests/cpu_top_tb.sv
`timescale 1ns/1ps

module cpu_top_tb;
  import cpu_pkg::*;

  localparam int XLEN       = 32;
  localparam int MUL_STAGES = 5;
  localparam int DIR_WORDS  = 24;
  localparam int RAND_WORDS = 64;
  localparam int ROM_WORDS  = DIR_WORDS + RAND_WORDS + 8;
  localparam logic [6:0] F7_BASE = 7'h00;
  localparam logic [6:0] F7_ALT  = 7'h20;
  localparam logic [6:0] F7_MUL  = 7'h01;

  logic            clk_i;
  logic            rst_i;
  logic [XLEN-1:0] imem_addr_o;
  logic [XLEN-1:0] imem_rdata_i;
  logic            retire_valid_o;
  logic [XLEN-1:0] retire_pc_o;
  reg_idx_t        retire_rd_o;
  logic [XLEN-1:0] retire_data_o;

  logic [31:0] rom [ROM_WORDS];
  bit          exp_retires [ROM_WORDS];
  reg_idx_t    exp_rd [ROM_WORDS];
  logic [31:0] exp_data [ROM_WORDS];
  int          retire_hits [ROM_WORDS];
  int          exp_total;
  int          retire_total;
  int          fill_idx;
  logic [31:0] lcg_state;

  logic        ret_in_rom;
  logic [29:0] ret_idx;
  logic        exp_ret_now;
  logic        seen_now;
  reg_idx_t    exp_rd_now;
  logic [31:0] exp_data_now;

  cpu_top #(
    .XLEN           (XLEN),
    .MUL_STAGES     (MUL_STAGES)
  ) i_cpu_top (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .imem_addr_o    (imem_addr_o),
    .imem_rdata_i   (imem_rdata_i),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

  // Custom-0 opcode is never issued by the core
  function automatic logic [31:0] nop_word(logic [31:0] addr);
    return {addr[31:7] ^ addr[24:0], 7'h0b};
  endfunction

  function automatic logic [31:0] r_type_word(logic [6:0] f7, logic [2:0] f3,
                                              logic [4:0] rd, logic [4:0] rs1,
                                              logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type_word(logic [11:0] imm, logic [4:0] rd,
                                              logic [4:0] rs1);
    return {imm, rs1, 3'd0, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Instruction memory answers in the same cycle
  assign imem_rdata_i = (imem_addr_o < 32'(4 * ROM_WORDS)) ? rom[imem_addr_o[31:2]]
                                                           : nop_word(imem_addr_o);

  assign ret_idx      = retire_pc_o[31:2];
  assign ret_in_rom   = (retire_pc_o[1:0] == 2'd0) && (retire_pc_o < 32'(4 * ROM_WORDS));
  assign exp_ret_now  = ret_in_rom && exp_retires[ret_idx];
  assign seen_now     = ret_in_rom && (retire_hits[ret_idx] != 0);
  assign exp_rd_now   = exp_rd[ret_idx];
  assign exp_data_now = exp_data[ret_idx];

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic value_mismatch(string what, logic [31:0] got, logic [31:0] exp);
    $display("[FAIL] %s: got %08h, expected %08h", what, got, exp);
    stop_run();
  endtask

  task automatic report_error(string text);
    $display("%s", text);
    stop_run();
  endtask

  task automatic put_word(logic [31:0] word);
    rom[fill_idx] = word;
    fill_idx++;
  endtask

  task automatic build_program();
    logic [31:0] r;
    // Back-to-back RAW on ALU results
    put_word(i_type_word(12'd5, 5'd1, 5'd0));
    put_word(i_type_word(12'hffd, 5'd2, 5'd1));
    put_word(r_type_word(F7_BASE, 3'd0, 5'd3, 5'd1, 5'd2));
    put_word(r_type_word(F7_ALT, 3'd0, 5'd4, 5'd3, 5'd1));
    // ALU reads a MUL result, then MUL and ALU write the same rd
    put_word(r_type_word(F7_MUL, 3'd0, 5'd5, 5'd3, 5'd4));
    put_word(r_type_word(F7_BASE, 3'd0, 5'd6, 5'd5, 5'd1));
    put_word(r_type_word(F7_MUL, 3'd0, 5'd7, 5'd6, 5'd6));
    put_word(i_type_word(12'd100, 5'd7, 5'd0));
    put_word(r_type_word(F7_BASE, 3'd4, 5'd1, 5'd7, 5'd2));
    put_word(nop_word(32'(4 * fill_idx)));
    // Fourth independent ALU op meets the finishing MUL
    put_word(r_type_word(F7_MUL, 3'd0, 5'd2, 5'd1, 5'd1));
    put_word(r_type_word(F7_BASE, 3'd6, 5'd3, 5'd4, 5'd6));
    put_word(r_type_word(F7_BASE, 3'd7, 5'd4, 5'd6, 5'd1));
    put_word(i_type_word(12'hfff, 5'd5, 5'd0));
    put_word(i_type_word(12'h7ff, 5'd6, 5'd0));
    put_word(r_type_word(F7_BASE, 3'd0, 5'd7, 5'd2, 5'd6));
    // x0 write retires its value but x0 still reads zero
    put_word(r_type_word(F7_BASE, 3'd0, 5'd0, 5'd1, 5'd1));
    put_word(r_type_word(F7_BASE, 3'd0, 5'd3, 5'd0, 5'd7));
    // Two MULs back to back hold the ALU for two cycles
    put_word(r_type_word(F7_MUL, 3'd0, 5'd4, 5'd5, 5'd5));
    put_word(r_type_word(F7_MUL, 3'd0, 5'd5, 5'd6, 5'd6));
    put_word(i_type_word(12'd3, 5'd1, 5'd0));
    put_word(i_type_word(12'd4, 5'd2, 5'd0));
    put_word(i_type_word(12'd5, 5'd3, 5'd0));
    put_word(r_type_word(F7_ALT, 3'd0, 5'd7, 5'd3, 5'd2));
    for (int n = 0; n < RAND_WORDS; n++) begin
      r = lcg_next();
      case (r[31:29])
        3'd0:    put_word(r_type_word(F7_BASE, 3'd0, r[28:26], r[25:23], r[22:20]));
        3'd1:    put_word(r_type_word(F7_ALT, 3'd0, r[28:26], r[25:23], r[22:20]));
        3'd2:    put_word(r_type_word(F7_BASE, 3'd7, r[28:26], r[25:23], r[22:20]));
        3'd3:    put_word(r_type_word(F7_BASE, 3'd6, r[28:26], r[25:23], r[22:20]));
        3'd4:    put_word(r_type_word(F7_BASE, 3'd4, r[28:26], r[25:23], r[22:20]));
        3'd5:    put_word(i_type_word(r[19:8], r[28:26], r[25:23]));
        default: put_word(r_type_word(F7_MUL, 3'd0, r[28:26], r[25:23], r[22:20]));
      endcase
    end
    while (fill_idx < ROM_WORDS) begin
      put_word(nop_word(32'(4 * fill_idx)));
    end
  endtask

  // In-order execution of the whole ROM gives one expected result per pc
  task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [9:0]  fn;
    bit          ok;
    for (int k = 0; k < 32; k++) begin
      regs[k] = '0;
    end
    exp_total = 0;
    for (int n = 0; n < ROM_WORDS; n++) begin
      w   = rom[n];
      a   = regs[w[19:15]];
      b   = regs[w[24:20]];
      fn  = {w[31:25], w[14:12]};
      ok  = 1'b1;
      res = '0;
      if (w[6:0] == OPC_OP_IMM && w[14:12] == 3'd0) begin
        res = a + {{20{w[31]}}, w[31:20]};
      end else if (w[6:0] == OPC_OP) begin
        case (fn)
          {F7_BASE, 3'd0}: res = a + b;
          {F7_ALT, 3'd0}:  res = a - b;
          {F7_BASE, 3'd4}: res = a ^ b;
          {F7_BASE, 3'd6}: res = a | b;
          {F7_BASE, 3'd7}: res = a & b;
          {F7_MUL, 3'd0}:  res = a * b;
          default:         ok = 1'b0;
        endcase
      end else begin
        ok = 1'b0;
      end
      exp_retires[n] = ok;
      exp_rd[n]      = w[11:7];
      exp_data[n]    = res;
      if (ok) begin
        exp_total++;
        if (w[11:7] != 5'd0) begin
          regs[w[11:7]] = res;
        end
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_i && retire_valid_o) begin
      retire_total <= retire_total + 1;
      if (ret_in_rom) begin
        retire_hits[ret_idx] <= retire_hits[ret_idx] + 1;
      end
    end
  end

  a_reset_addr: assert property (@(posedge clk_i) $rose(rst_i) |-> imem_addr_o == '0)
    else value_mismatch("imem_addr_o after reset", $sampled(imem_addr_o), '0);

  a_retire_legal: assert property (@(posedge clk_i) disable iff (!rst_i)
      retire_valid_o |-> exp_ret_now)
    else report_error($sformatf("pc %08h retired but holds no issuable instruction",
                                $sampled(retire_pc_o)));

  a_retire_once: assert property (@(posedge clk_i) disable iff (!rst_i)
      retire_valid_o |-> !seen_now)
    else report_error($sformatf("pc %08h retired a second time", $sampled(retire_pc_o)));

  a_retire_rd: assert property (@(posedge clk_i) disable iff (!rst_i)
      retire_valid_o && exp_ret_now |-> retire_rd_o == exp_rd_now)
    else value_mismatch($sformatf("retire_rd_o for pc %08h", $sampled(retire_pc_o)),
                        $sampled(retire_rd_o), $sampled(exp_rd_now));

  a_retire_data: assert property (@(posedge clk_i) disable iff (!rst_i)
      retire_valid_o && exp_ret_now |-> retire_data_o == exp_data_now)
    else value_mismatch($sformatf("retire_data_o for pc %08h", $sampled(retire_pc_o)),
                        $sampled(retire_data_o), $sampled(exp_data_now));

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Watchdog of 40 cycles per program word
  initial begin
    repeat (40 * ROM_WORDS) @(posedge clk_i);
    report_error($sformatf("timeout with %0d of %0d instructions retired",
                           retire_total, exp_total));
  end

  initial begin
    rst_i     = 1'b0;
    lcg_state = 32'hb055_1832;
    fill_idx  = 0;
    build_program();
    run_model();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b1;
    while (retire_total < exp_total) begin
      @(posedge clk_i);
    end
    // Give stray or repeated retires time to show up
    repeat (4 * MUL_STAGES) @(posedge clk_i);
    for (int n = 0; n < ROM_WORDS; n++) begin
      a_retire_count: assert (retire_hits[n] == int'(exp_retires[n]))
        else report_error($sformatf("pc %08h retired %0d times", 4 * n, retire_hits[n]));
    end
    if (i_cpu_top.i_cpu_top_sva.fail_count != 0) begin
      report_error("bound port assertions on cpu_top failed");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule
